//--- all.f
mem_pkg.sv
store_lane_align.sv
data_ram_bank.sv
load_extend.sv
mem_access_ctrl.sv
data_mem_top.sv
data_mem_assert.sv
tb_data_mem.sv

//--- data_mem_assert.sv
`timescale 1ns/100ps

module data_mem_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     req,
    input logic                     ack,
    input logic [mem_pkg::XLEN-1:0] rdata,
    input logic [mem_pkg::XLEN-1:0] result,
    input mem_pkg::ctrl_state_e     state
);
    import mem_pkg::*;

    int fail_count = 0;

    // also covers the first edge after release
    ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
    else
    begin
        $error("ack high during or right after reset");
        fail_count++;
    end

    ack_two_edges: assert property (@(posedge clk) disable iff (rst)
                                    state == IDLE && req |=> !ack ##1 ack)
    else
    begin
        $error("ack did not rise two edges after the request was taken");
        fail_count++;
    end

    outputs_stable: assert property (@(posedge clk) disable iff (rst)
                                     ack && $past(ack) |-> $stable(rdata) && $stable(result))
    else
    begin
        $error("rdata or result changed while ack was high");
        fail_count++;
    end

    ack_falls: assert property (@(posedge clk) disable iff (rst)
                                ack && !req |=> !ack)
    else
    begin
        $error("ack did not fall one edge after req dropped");
        fail_count++;
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
                                    $rose(ack) |-> req)
    else
    begin
        $error("ack rose without a pending request");
        fail_count++;
    end

endmodule

bind data_mem_top data_mem_assert assert_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .rdata  (rdata),
    .result (result),
    .state  (ctrl_i.state)
);

//--- data_mem_top.sv
`timescale 1ns/100ps

module data_mem_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    output logic                     ack,
    input  logic                     we,
    input  mem_pkg::mem_mode_e       mode,
    input  mem_pkg::result_src_e     result_src,
    input  logic [mem_pkg::XLEN-1:0] addr,
    input  logic [mem_pkg::XLEN-1:0] wdata,
    output logic [mem_pkg::XLEN-1:0] rdata,
    output logic [mem_pkg::XLEN-1:0] result
);
    import mem_pkg::*;

    logic [1:0]               offset;
    logic [MEM_ADDR_BITS-3:0] word_addr;
    mem_mode_e                mode_q;
    logic [XLEN-1:0]          wdata_q;
    logic                     ram_wr;
    logic                     ram_rd;
    logic [3:0]               byte_en;
    logic [XLEN-1:0]          lane_data;
    logic [XLEN-1:0]          rword;
    logic [XLEN-1:0]          load_data;

    mem_access_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .we         (we),
        .mode       (mode),
        .result_src (result_src),
        .addr       (addr),
        .wdata      (wdata),
        .load_data  (load_data),
        .ack        (ack),
        .offset     (offset),
        .word_addr  (word_addr),
        .mode_q     (mode_q),
        .wdata_q    (wdata_q),
        .ram_wr     (ram_wr),
        .ram_rd     (ram_rd),
        .rdata      (rdata),
        .result     (result)
    );

    store_lane_align align_i (
        .offset    (offset),
        .mode      (mode_q),
        .wdata     (wdata_q),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    data_ram_bank ram_i (
        .clk       (clk),
        .word_addr (word_addr),
        .wr        (ram_wr),
        .byte_en   (byte_en),
        .lane_data (lane_data),
        .rd        (ram_rd),
        .rword     (rword)
    );

    load_extend ext_i (
        .rword     (rword),
        .offset    (offset),
        .mode      (mode_q),
        .load_data (load_data)
    );

endmodule

//--- data_ram_bank.sv
`timescale 1ns/100ps

module data_ram_bank (
    input  logic                              clk,
    input  logic [mem_pkg::MEM_ADDR_BITS-3:0] word_addr,
    input  logic                              wr,
    input  logic [3:0]                        byte_en,
    input  logic [mem_pkg::XLEN-1:0]          lane_data,
    input  logic                              rd,
    output logic [mem_pkg::XLEN-1:0]          rword
);
    import mem_pkg::*;

    // one byte-wide bank per lane, lane 0 holds bits 31:24
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        logic [7:0] bank [WORD_DEPTH];
        logic [7:0] wbyte;
        logic [7:0] rbyte;

        assign wbyte = lane_data[XLEN-1-8*i -: 8];

        always_ff @(posedge clk)
        begin
            if (wr && byte_en[i])
            begin
                bank[word_addr] <= wbyte;
            end
        end

        always_ff @(posedge clk)
        begin
            if (rd)
            begin
                rbyte <= bank[word_addr];                   // held until the next read
            end
        end

        assign rword[XLEN-1-8*i -: 8] = rbyte;
    end

endmodule

//--- load_extend.sv
`timescale 1ns/100ps

module load_extend (
    input  logic [mem_pkg::XLEN-1:0] rword,
    input  logic [1:0]               offset,
    input  mem_pkg::mem_mode_e       mode,
    output logic [mem_pkg::XLEN-1:0] load_data
);
    import mem_pkg::*;

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    // big-endian, offset 0 picks the top of the word
    always_comb
    begin
        if (offset[1])
        begin
            half_sel = rword[15:0];
        end
        else
        begin
            half_sel = rword[31:16];
        end
    end

    always_comb
    begin
        case (offset)
            2'd0:    byte_sel = rword[31:24];
            2'd1:    byte_sel = rword[23:16];
            2'd2:    byte_sel = rword[15:8];
            default: byte_sel = rword[7:0];
        endcase
    end

    always_comb
    begin
        case (mode)
            MODE_WORD:
            begin
                load_data = rword;
            end
            MODE_HALF:
            begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            MODE_BYTE:
            begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            MODE_HALF_U:
            begin
                load_data = {16'h0000, half_sel};
            end
            MODE_BYTE_U:
            begin
                load_data = {24'h000000, byte_sel};
            end
            default:
            begin
                load_data = '0;
            end
        endcase
    end

endmodule

//--- mem_access_ctrl.sv
`timescale 1ns/100ps

module mem_access_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req,
    input  logic                              we,
    input  mem_pkg::mem_mode_e                mode,
    input  mem_pkg::result_src_e              result_src,
    input  logic [mem_pkg::XLEN-1:0]          addr,
    input  logic [mem_pkg::XLEN-1:0]          wdata,
    input  logic [mem_pkg::XLEN-1:0]          load_data,
    output logic                              ack,
    output logic [1:0]                        offset,
    output logic [mem_pkg::MEM_ADDR_BITS-3:0] word_addr,
    output mem_pkg::mem_mode_e                mode_q,
    output logic [mem_pkg::XLEN-1:0]          wdata_q,
    output logic                              ram_wr,
    output logic                              ram_rd,
    output logic [mem_pkg::XLEN-1:0]          rdata,
    output logic [mem_pkg::XLEN-1:0]          result
);
    import mem_pkg::*;

    ctrl_state_e state;
    logic        we_q;
    result_src_e res_src_q;
    logic [XLEN-1:0] addr_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            ack   <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req)
                    begin
                        state <= ACCESS;
                    end
                end
                ACCESS:
                begin
                    state <= DONE;
                    ack   <= 1'b1;                          // ram write or read lands here
                end
                DONE:
                begin
                    if (!req)
                    begin
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default:
                begin
                    state <= IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // request fields, taken once per transfer
    always_ff @(posedge clk)
    begin
        if (state == IDLE && req)
        begin
            we_q      <= we;
            mode_q    <= mode;
            res_src_q <= result_src;
            addr_q    <= addr;
            wdata_q   <= wdata;
        end
    end

    assign offset    = addr_q[1:0];
    assign word_addr = addr_q[MEM_ADDR_BITS-1:2];

    // one-cycle strobes in ACCESS
    assign ram_wr = (state == ACCESS) && we_q;
    assign ram_rd = (state == ACCESS) && !we_q;

    // rword and the latched fields do not move in DONE
    assign rdata = load_data;

    always_comb
    begin
        case (res_src_q)
            RES_MEM: result = load_data;
            RES_PC4: result = addr_q + 32'd4;
            default: result = addr_q;                       // RES_ALU and code 3
        endcase
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    localparam int XLEN          = 32;
    localparam int MEM_ADDR_BITS = 12;                         // 4 KiB byte space
    localparam int WORD_DEPTH    = 2 ** (MEM_ADDR_BITS - 2);   // 1024 words
    localparam int LANES         = XLEN / 8;

    // access width and extension, codes as used by the decoder
    typedef enum logic [2:0] {
        MODE_WORD   = 3'd1,
        MODE_HALF   = 3'd2,
        MODE_BYTE   = 3'd3,
        MODE_HALF_U = 3'd4,
        MODE_BYTE_U = 3'd5
    } mem_mode_e;

    // writeback source, code 3 is unused and treated like RES_ALU
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        DONE   = 2'd2
    } ctrl_state_e;

endpackage

//--- store_lane_align.sv
`timescale 1ns/100ps

module store_lane_align (
    input  logic [1:0]               offset,
    input  mem_pkg::mem_mode_e       mode,
    input  logic [mem_pkg::XLEN-1:0] wdata,
    output logic [3:0]               byte_en,
    output logic [mem_pkg::XLEN-1:0] lane_data
);
    import mem_pkg::*;

    // byte_en[i] is lane i, lane 0 is the most significant byte
    always_comb
    begin
        byte_en   = 4'b0000;
        lane_data = wdata;
        case (mode)
            MODE_WORD:
            begin
                byte_en   = 4'b1111;
                lane_data = wdata;
            end
            MODE_HALF,
            MODE_HALF_U:
            begin
                lane_data = {2{wdata[15:0]}};               // same half in both slots
                if (offset[1])
                begin
                    byte_en = 4'b1100;                      // lanes 2 and 3
                end
                else
                begin
                    byte_en = 4'b0011;                      // lanes 0 and 1
                end
            end
            MODE_BYTE,
            MODE_BYTE_U:
            begin
                lane_data = {4{wdata[7:0]}};
                case (offset)
                    2'd0:    byte_en = 4'b0001;
                    2'd1:    byte_en = 4'b0010;
                    2'd2:    byte_en = 4'b0100;
                    default: byte_en = 4'b1000;
                endcase
            end
            default:
            begin
                byte_en = 4'b0000;                          // unknown mode touches nothing
            end
        endcase
    end

endmodule

//--- tb_data_mem.sv
`timescale 1ns/100ps

module tb_data_mem;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 8;
    localparam int REGION_BASE  = 'h100;                    // 16 words under test
    localparam int REGION_WORDS = 16;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_DIRECTED = 55;
    localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_NS   = (NUM_OPS * 8 + RST_CYCLES + 4) * CLK_PERIOD;

    logic            clk;
    logic            rst;
    logic            req;
    logic            ack;
    logic            we;
    mem_mode_e       mode;
    result_src_e     result_src;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] exp_rdata;
    logic [XLEN-1:0] exp_result;
    logic            chk_rdata;
    logic            chk_result;
    logic [7:0]      mem_model [0:4095];                    // byte image, big-endian words
    logic [31:0]     lcg_state = 32'd62;
    int              ops_done;

    data_mem_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .we         (we),
        .mode       (mode),
        .result_src (result_src),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .result     (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random upper bits, so result sees the full address
    function automatic logic [XLEN-1:0] make_addr(input int word, input int off);
        logic [31:0] r;
        r = next_rand();
        return {r[31:12], 12'(REGION_BASE + word * 4 + off)};
    endfunction

    function automatic logic [XLEN-1:0] model_load(input mem_mode_e m, input logic [XLEN-1:0] a);
        logic [11:0] base;
        logic [11:0] hb;
        logic [15:0] h;
        logic [7:0]  b;
        base = {a[11:2], 2'b00};
        hb   = base + {10'd0, a[1], 1'b0};
        h    = {mem_model[hb], mem_model[hb + 12'd1]};
        b    = mem_model[a[11:0]];
        case (m)
            MODE_WORD:   return {mem_model[base], mem_model[base + 12'd1],
                                 mem_model[base + 12'd2], mem_model[base + 12'd3]};
            MODE_HALF:   return {{16{h[15]}}, h};
            MODE_BYTE:   return {{24{b[7]}}, b};
            MODE_HALF_U: return {16'h0000, h};
            MODE_BYTE_U: return {24'h000000, b};
            default:     return '0;
        endcase
    endfunction

    function automatic void model_store(input mem_mode_e m, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] d);
        logic [11:0] base;
        logic [11:0] hb;
        base = {a[11:2], 2'b00};
        hb   = base + {10'd0, a[1], 1'b0};
        case (m)
            MODE_WORD:
            begin
                mem_model[base]         = d[31:24];
                mem_model[base + 12'd1] = d[23:16];
                mem_model[base + 12'd2] = d[15:8];
                mem_model[base + 12'd3] = d[7:0];
            end
            MODE_HALF, MODE_HALF_U:
            begin
                mem_model[hb]         = d[15:8];
                mem_model[hb + 12'd1] = d[7:0];
            end
            MODE_BYTE, MODE_BYTE_U: mem_model[a[11:0]] = d[7:0];
            default:                mem_model[a[11:0]] = mem_model[a[11:0]];
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_result(input result_src_e rs,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] load_val);
        case (rs)
            RES_MEM: return load_val;
            RES_PC4: return a + 32'd4;
            default: return a;                              // alu and code 3
        endcase
    endfunction

    // one four-phase transfer, called right after a rising edge
    task automatic do_request(input logic w, input mem_mode_e m, input result_src_e rs,
                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] d);
        logic [XLEN-1:0] load_val;
        int              hold;
        load_val = '0;
        if (w)
            model_store(m, a, d);
        else
            load_val = model_load(m, a);
        hold       = int'(next_rand() % 4);              // back-pressure in DONE
        req        <= 1'b1;
        we         <= w;
        mode       <= m;
        result_src <= rs;
        addr       <= a;
        wdata      <= d;
        exp_rdata  <= load_val;
        exp_result <= expected_result(rs, a, load_val);
        chk_rdata  <= !w;
        chk_result <= !(w && rs == RES_MEM);
        do @(posedge clk); while (!ack);
        repeat (hold) @(posedge clk);
        req <= 1'b0;
        do @(posedge clk); while (ack);
        ops_done++;
    endtask

    check_rdata: assert property (@(posedge clk) disable iff (rst)
                                  ack && chk_rdata |-> rdata == exp_rdata)
    else
    begin
        $display("FAILED at %0t: rdata expected %h, got %h",
                 $time, $sampled(exp_rdata), $sampled(rdata));
        $display("STATUS: FAIL");
        $fatal(1, "rdata check failed");
    end

    check_result: assert property (@(posedge clk) disable iff (rst)
                                   ack && chk_result |-> result == exp_result)
    else
    begin
        $display("FAILED at %0t: result expected %h, got %h",
                 $time, $sampled(exp_result), $sampled(result));
        $display("STATUS: FAIL");
        $fatal(1, "result check failed");
    end

    // bound handshake checks count their failures
    initial
    begin
        wait (dut_i.assert_i.fail_count != 0);
        $display("a handshake protocol assertion failed at %0t", $time);
        $display("STATUS: FAIL");
        $fatal(1, "protocol assertion failed");
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: requests did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [XLEN-1:0] a;
        logic [31:0]     r;
        rst        = 1'b1;
        req        = 1'b0;
        we         = 1'b0;
        mode       = MODE_WORD;
        result_src = RES_ALU;
        addr       = '0;
        wdata      = '0;
        exp_rdata  = '0;
        exp_result = '0;
        chk_rdata  = 1'b0;
        chk_result = 1'b0;
        ops_done   = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < REGION_WORDS; i++)          // known contents for every load
            do_request(1'b1, MODE_WORD, RES_ALU, make_addr(i, 0), next_rand());

        a = make_addr(3, 0);                                // word round trip, byte order
        do_request(1'b1, MODE_WORD, RES_PC4, a, 32'h1234_5678);
        do_request(1'b0, MODE_WORD, RES_MEM, a, '0);
        for (int k = 0; k < 4; k++)
            do_request(1'b0, MODE_BYTE_U, result_src_e'(k[1:0]), a + k, '0);

        a = make_addr(5, 0);                                // partial stores merge
        do_request(1'b1, MODE_HALF, RES_ALU, a, 32'hAAAA_C3D4);
        do_request(1'b0, MODE_WORD, RES_MEM, a, '0);
        do_request(1'b1, MODE_HALF_U, RES_PC4, a + 3, 32'h5555_E1F2);
        do_request(1'b0, MODE_WORD, RES_MEM, a, '0);
        for (int k = 0; k < 4; k++)
        begin
            do_request(1'b1, k[0] ? MODE_BYTE_U : MODE_BYTE, RES_ALU, a + 4 + k, 32'h90 + k);
            do_request(1'b0, MODE_WORD, RES_MEM, a + 4, '0);
        end

        a = make_addr(7, 0);                                // top bit set in every byte
        do_request(1'b1, MODE_WORD, RES_ALU, a, 32'h8091_A2B3);
        for (int k = 0; k < 4; k++)
        begin
            do_request(1'b0, MODE_HALF,   RES_MEM, a + k, '0);
            do_request(1'b0, MODE_HALF_U, RES_MEM, a + k, '0);
            do_request(1'b0, MODE_BYTE,   RES_MEM, a + k, '0);
            do_request(1'b0, MODE_BYTE_U, RES_MEM, a + k, '0);
        end

        for (int k = 0; k < 4; k++)
            do_request(1'b0, MODE_WORD, result_src_e'(k[1:0]), make_addr(3, 0), '0);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            r = next_rand();
            do_request(r[31], mem_mode_e'(3'(r[29:22] % 5 + 1)), result_src_e'(r[21:20]),
                       make_addr(int'(r[19:16]), int'(r[15:14])), next_rand());
        end

        @(negedge clk);                                     // last edge's checks settle
        $display("%0d requests completed", ops_done);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
